// File: bench/sb_bridge_model.svh
// sideband bridge stimulus and reference model

`ifndef sb_bridge_model_svh
`define sb_bridge_model_svh

// ------------------------------------------------------------
// pseudo random source
// ------------------------------------------------------------

// 16 bit fibonacci lfsr with taps 16 14 13 11
logic [15:0] lfsr_state = 16'd42;

function automatic logic lfsr_step();
  logic fb;
  fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
  lfsr_state = {lfsr_state[14:0], fb};
  return fb;
endfunction

// every bit taken costs one lfsr step
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_step()};
  end
  return v;
endfunction

// ------------------------------------------------------------
// message generator
// ------------------------------------------------------------

// lengths of one to three flits, with one flit somewhat more likely
function automatic int gen_len();
  logic [1:0] r;
  r = 2'(rand_bits(2));
  return (r == 2'd0) ? 1 : int'(r);
endfunction

// roughly one message in four carries a register access opcode
function automatic logic [sb_bridge_pkg::opc_w-1:0] gen_opcode();
  logic [sb_bridge_pkg::opc_w-1:0] opc;
  if (rand_bits(2) == 0) begin
    opc = 8'(rand_bits(3));
  end else begin
    opc = 8'(rand_bits(8));
    // push low values out of the register access range
    if (opc < 8'h08) begin
      opc = opc + 8'h08;
    end
  end
  return opc;
endfunction

// reference decision, opcodes 00 to 07 are dropped and all others go through
function automatic logic is_forwarded(input logic [sb_bridge_pkg::opc_w-1:0] opc);
  return opc > 8'h07;
endfunction

`endif

// File: bench/sb_bridge_tb.sv
// sideband bridge testbench

`timescale 1ns/1ps

module sb_bridge_tb;

  // each message is at most 3 flits with up to about 10 cycles apiece
  localparam int num_msgs = 200;
  localparam int max_cycles = num_msgs * 3 * 10;

  logic                 side_clk;
  logic                 side_rst_b;
  logic                 pc_put;
  logic                 np_put;
  sb_bridge_pkg::flit_t in_flit;
  logic                 pc_free;
  logic                 np_free;
  logic                 m_put;
  logic                 m_np;
  sb_bridge_pkg::flit_t m_flit;
  logic                 m_trdy;
  logic                 regacc_drop;

  // expected egress flits in put order, one queue per channel
  sb_bridge_pkg::flit_t exp_pc_q[$];
  sb_bridge_pkg::flit_t exp_np_q[$];
  sb_bridge_pkg::flit_t exp_flit;

  int mismatch_errs = 0;
  int other_errs = 0;
  int drop_exp = 0;
  int drop_seen = 0;
  int cycle_cnt = 0;

  // egress message lock and stalled offer as seen from outside
  logic                 lock_q = 1'b0;
  logic                 lock_np_q = 1'b0;
  logic                 stall_q = 1'b0;
  logic                 stall_np_q = 1'b0;
  sb_bridge_pkg::flit_t stall_flit_q;

  `include "sb_bridge_model.svh"

  sb_bridge sb_bridge_inst (
    .side_clk    (side_clk),
    .side_rst_b  (side_rst_b),
    .pc_put      (pc_put),
    .np_put      (np_put),
    .in_flit     (in_flit),
    .pc_free     (pc_free),
    .np_free     (np_free),
    .m_put       (m_put),
    .m_np        (m_np),
    .m_flit      (m_flit),
    .m_trdy      (m_trdy),
    .regacc_drop (regacc_drop)
  );

  initial side_clk = 1'b0;
  always #10 side_clk = ~side_clk;

  task automatic check_value(input string name, input logic [32:0] got, input logic [32:0] exp);
    assert (got === exp) else begin
      mismatch_errs++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic note_failure(input string what);
    other_errs++;
    $display("%s", what);
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  // m_trdy changes 1 ns after the edge and the put decision follows
  // 1 ns later, once free has settled against the new m_trdy
  task automatic tick();
    @(posedge side_clk);
    #1;
    m_trdy = 1'(rand_bits(1));
    #1;
  endtask

  function automatic logic chan_free(input sb_bridge_pkg::chan_e ch);
    return (ch == sb_bridge_pkg::chan_pc) ? pc_free : np_free;
  endfunction

  task automatic send_msg();
    sb_bridge_pkg::chan_e            ch;
    sb_bridge_pkg::flit_t            f;
    logic [sb_bridge_pkg::opc_w-1:0] opc;
    logic                            fwd;
    int                              len;
    ch  = sb_bridge_pkg::chan_e'(rand_bits(1));
    len = gen_len();
    opc = gen_opcode();
    fwd = is_forwarded(opc);
    if (!fwd) begin
      drop_exp++;
    end
    for (int i = 0; i < len; i++) begin
      f.payload = rand_bits(32);
      if (i == 0) begin
        f.payload[sb_bridge_pkg::opc_lsb +: sb_bridge_pkg::opc_w] = opc;
      end
      f.eom = (i == len - 1);
      tick();
      // dropped flits are never held back by free
      while (fwd && !chan_free(ch)) begin
        pc_put = 1'b0;
        np_put = 1'b0;
        tick();
      end
      in_flit = f;
      pc_put  = (ch == sb_bridge_pkg::chan_pc);
      np_put  = (ch == sb_bridge_pkg::chan_np);
      if (fwd && ch == sb_bridge_pkg::chan_pc) begin
        exp_pc_q.push_back(f);
      end else if (fwd) begin
        exp_np_q.push_back(f);
      end
    end
  endtask

  initial begin
    side_rst_b = 1'b0;
    pc_put     = 1'b0;
    np_put     = 1'b0;
    in_flit    = '0;
    m_trdy     = 1'b0;
    repeat (5) @(posedge side_clk);
    #1;
    side_rst_b = 1'b1;
    #1;
    check_value("m_put", m_put, 1'b0);
    check_value("regacc_drop", regacc_drop, 1'b0);
    check_value("pc_free", pc_free, 1'b1);
    check_value("np_free", np_free, 1'b1);
    for (int m = 0; m < num_msgs; m++) begin
      send_msg();
    end
    tick();
    pc_put = 1'b0;
    np_put = 1'b0;
    // let the stages drain and the last drop pulse arrive
    while (exp_pc_q.size() != 0 || exp_np_q.size() != 0) begin
      tick();
    end
    repeat (3) tick();
    assert (drop_seen == drop_exp) else begin
      note_failure($sformatf("expected %0d register access drops but saw %0d pulses",
                             drop_exp, drop_seen));
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs + other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // ------------------------------------------------------------
  // egress comparison
  // ------------------------------------------------------------

  // sampled on the edge, before any flop or input has moved
  always @(posedge side_clk) begin
    if (side_rst_b) begin
      if (regacc_drop) begin
        drop_seen++;
      end
      // a stalled offer must come back unchanged
      if (stall_q) begin
        check_value("m_put", m_put, 1'b1);
        check_value("m_flit", m_flit, stall_flit_q);
        check_value("m_np", m_np, stall_np_q);
      end
      // np may not pass a waiting pc flit
      if (m_put && !m_np && !m_trdy && !(lock_q && lock_np_q)) begin
        assert (!np_free) else begin
          note_failure("np_free was high while a pc flit waited on egress");
        end
      end
      if (m_put && m_trdy) begin
        if (lock_q) begin
          check_value("m_np", m_np, lock_np_q);
        end else begin
          assert (is_forwarded(m_flit.payload[sb_bridge_pkg::opc_lsb +: sb_bridge_pkg::opc_w]))
          else begin
            note_failure("a register access message appeared on egress");
          end
        end
        if ((m_np && exp_np_q.size() == 0) || (!m_np && exp_pc_q.size() == 0)) begin
          note_failure("a flit left on egress with none expected on its channel");
        end else begin
          exp_flit = m_np ? exp_np_q.pop_front() : exp_pc_q.pop_front();
          check_value("m_flit", m_flit, exp_flit);
        end
        lock_q    = !m_flit.eom;
        lock_np_q = m_np;
      end
      stall_q      = m_put && !m_trdy;
      stall_np_q   = m_np;
      stall_flit_q = m_flit;
    end
  end

  // ------------------------------------------------------------
  // run limit
  // ------------------------------------------------------------

  always @(posedge side_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      note_failure($sformatf("run did not finish within %0d cycles", max_cycles));
      $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
      $display("Verification failed");
      $finish;
    end
  end

endmodule

// File: compile.f
+incdir+bench
src/sb_bridge_pkg.sv
src/flit_classifier.sv
src/flit_stage.sv
src/egress_select.sv
src/sb_bridge.sv
bench/sb_bridge_tb.sv

// File: src/egress_select.sv
// egress channel selector

`timescale 1ns/1ps

module egress_select (
  input  logic                                                       side_clk,
  input  logic                                                       side_rst_b,
  input  logic                 [sb_bridge_pkg::num_chan-1:0]         valid,
  input  sb_bridge_pkg::flit_t [sb_bridge_pkg::num_chan-1:0]         stage_flit,
  input  logic                                                       m_trdy,
  output logic                                                       m_put,
  output logic                                                       m_np,
  output sb_bridge_pkg::flit_t                                       m_flit,
  output logic                 [sb_bridge_pkg::num_chan-1:0]         pop,
  output logic                                                       pc_free,
  output logic                                                       np_free
);

  // message in progress on egress, one flag per channel
  logic [sb_bridge_pkg::num_chan-1:0] msgip_q;

  // a flit was offered and not taken on the previous cycle
  logic stall_q;
  sb_bridge_pkg::chan_e sel_q;

  sb_bridge_pkg::chan_e sel;
  logic xfer;

  // ------------------------------------------------------------
  // channel choice
  // ------------------------------------------------------------

  // a locked channel owns the port until its eom goes out, and a
  // stalled offer keeps its channel so the flit stays put
  // otherwise pc is preferred over np
  always_comb begin
    if (msgip_q[sb_bridge_pkg::chan_np]) begin
      sel = sb_bridge_pkg::chan_np;
    end else if (msgip_q[sb_bridge_pkg::chan_pc]) begin
      sel = sb_bridge_pkg::chan_pc;
    end else if (stall_q) begin
      sel = sel_q;
    end else if (valid[sb_bridge_pkg::chan_pc]) begin
      sel = sb_bridge_pkg::chan_pc;
    end else begin
      sel = sb_bridge_pkg::chan_np;
    end
  end

  assign m_put  = valid[sel];
  assign m_np   = (sel == sb_bridge_pkg::chan_np);
  assign m_flit = stage_flit[sel];
  assign xfer   = m_put & m_trdy;

  always_comb begin
    for (int ch = 0; ch < sb_bridge_pkg::num_chan; ch++) begin
      pop[ch] = xfer & (sel == sb_bridge_pkg::chan_e'(ch));
    end
  end

  // ------------------------------------------------------------
  // lock and stall tracking
  // ------------------------------------------------------------

  always_ff @(posedge side_clk or negedge side_rst_b) begin
    if (!side_rst_b) begin
      msgip_q <= '0;
      stall_q <= 1'b0;
      sel_q   <= sb_bridge_pkg::chan_pc;
    end else begin
      if (xfer) begin
        msgip_q[sel] <= ~m_flit.eom;
      end
      stall_q <= m_put & ~m_trdy;
      sel_q   <= sel;
    end
  end

  // ------------------------------------------------------------
  // free signals
  // ------------------------------------------------------------

  // a stage is free when empty or when its flit leaves this cycle
  assign pc_free = ~valid[sb_bridge_pkg::chan_pc] | pop[sb_bridge_pkg::chan_pc];

  // np also waits for any pending or partly sent pc message, unless
  // an np message is already underway and must be allowed to finish
  assign np_free = (~valid[sb_bridge_pkg::chan_np] | pop[sb_bridge_pkg::chan_np]) &
                   (msgip_q[sb_bridge_pkg::chan_np] |
                    ~(msgip_q[sb_bridge_pkg::chan_pc] | valid[sb_bridge_pkg::chan_pc]));

  // an offered flit may not change or vanish before the receiver takes it
  a_hold_offer: assert property (
    @(posedge side_clk) disable iff (!side_rst_b)
    (m_put && !m_trdy) |=> (m_put && $stable(m_flit) && $stable(m_np))
  );

endmodule

// File: src/flit_classifier.sv
// ingress message classifier

`timescale 1ns/1ps

module flit_classifier (
  input  logic                                side_clk,
  input  logic                                side_rst_b,
  input  logic                                pc_put,
  input  logic                                np_put,
  input  sb_bridge_pkg::flit_t                in_flit,
  output logic [sb_bridge_pkg::num_chan-1:0] load,
  output sb_bridge_pkg::flit_t                load_flit,
  output logic                                regacc_drop
);

  // put strobes gathered into one vector indexed by channel
  logic [sb_bridge_pkg::num_chan-1:0] put;

  // eom of a dropped message seen on a channel this cycle
  logic [sb_bridge_pkg::num_chan-1:0] drop_eom;

  // opcode decode of the flit on the shared ingress bus
  logic first_regacc;

  sb_bridge_pkg::msg_state_e state_q [sb_bridge_pkg::num_chan];
  sb_bridge_pkg::msg_state_e state_d [sb_bridge_pkg::num_chan];

  assign put[sb_bridge_pkg::chan_pc] = pc_put;
  assign put[sb_bridge_pkg::chan_np] = np_put;

  // only meaningful when the channel being put is in st_first
  assign first_regacc =
    sb_bridge_pkg::is_regacc(in_flit.payload[sb_bridge_pkg::opc_lsb +: sb_bridge_pkg::opc_w]);

  // both stages see the same flit, load picks which one captures it
  assign load_flit = in_flit;

  // ------------------------------------------------------------
  // claim or ignore tracking
  // ------------------------------------------------------------

  // the first flit decides the fate of the whole message and the
  // state then remembers it until the eom flit goes by
  always_comb begin
    for (int ch = 0; ch < sb_bridge_pkg::num_chan; ch++) begin
      state_d[ch]  = state_q[ch];
      load[ch]     = 1'b0;
      drop_eom[ch] = 1'b0;
      if (put[ch]) begin
        case (state_q[ch])
          sb_bridge_pkg::st_first: begin
            load[ch]     = ~first_regacc;
            drop_eom[ch] = first_regacc & in_flit.eom;
            // a single flit message leaves the state in st_first
            if (!in_flit.eom) begin
              state_d[ch] = first_regacc ? sb_bridge_pkg::st_drop : sb_bridge_pkg::st_fwd;
            end
          end
          sb_bridge_pkg::st_fwd: begin
            load[ch] = 1'b1;
            if (in_flit.eom) begin
              state_d[ch] = sb_bridge_pkg::st_first;
            end
          end
          sb_bridge_pkg::st_drop: begin
            // body flits of a dropped message are simply swallowed
            drop_eom[ch] = in_flit.eom;
            if (in_flit.eom) begin
              state_d[ch] = sb_bridge_pkg::st_first;
            end
          end
          default: begin
            state_d[ch] = sb_bridge_pkg::st_first;
          end
        endcase
      end
    end
  end

  always_ff @(posedge side_clk or negedge side_rst_b) begin
    if (!side_rst_b) begin
      for (int ch = 0; ch < sb_bridge_pkg::num_chan; ch++) begin
        state_q[ch] <= sb_bridge_pkg::st_first;
      end
      regacc_drop <= 1'b0;
    end else begin
      state_q     <= state_d;
      // one pulse per dropped message, one cycle after its eom edge
      regacc_drop <= |drop_eom;
    end
  end

  // the sender shares one flit bus between the two channels
  a_one_put: assert property (
    @(posedge side_clk) disable iff (!side_rst_b)
    !(pc_put && np_put)
  );

endmodule

// File: src/flit_stage.sv
// one flit channel holding stage

`timescale 1ns/1ps

module flit_stage (
  input  logic                 side_clk,
  input  logic                 side_rst_b,
  input  logic                 load,
  input  sb_bridge_pkg::flit_t load_flit,
  input  logic                 pop,
  output logic                 valid,
  output sb_bridge_pkg::flit_t stage_flit
);

  // ------------------------------------------------------------
  // occupancy
  // ------------------------------------------------------------

  // load wins over pop, so a flit can be replaced in the same
  // cycle that the previous one leaves on the egress port
  always_ff @(posedge side_clk or negedge side_rst_b) begin
    if (!side_rst_b) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (pop) begin
      valid <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // flit register
  // ------------------------------------------------------------

  // contents only matter while valid is high
  always_ff @(posedge side_clk) begin
    if (load) begin
      stage_flit <= load_flit;
    end
  end

  // the free signal from the selector must keep the sender from
  // overwriting a flit that has not been accepted yet
  a_no_overrun: assert property (
    @(posedge side_clk) disable iff (!side_rst_b)
    load |-> (!valid || pop)
  );

endmodule

// File: src/sb_bridge.sv
// sideband message bridge core

`timescale 1ns/1ps

module sb_bridge (
  input  logic                 side_clk,
  input  logic                 side_rst_b,
  input  logic                 pc_put,
  input  logic                 np_put,
  input  sb_bridge_pkg::flit_t in_flit,
  output logic                 pc_free,
  output logic                 np_free,
  output logic                 m_put,
  output logic                 m_np,
  output sb_bridge_pkg::flit_t m_flit,
  input  logic                 m_trdy,
  output logic                 regacc_drop
);

  // ------------------------------------------------------------
  // internal nets
  // ------------------------------------------------------------

  // classifier to stages
  logic [sb_bridge_pkg::num_chan-1:0] load;
  sb_bridge_pkg::flit_t               load_flit;

  // stages to selector and back
  logic                 [sb_bridge_pkg::num_chan-1:0] valid;
  sb_bridge_pkg::flit_t [sb_bridge_pkg::num_chan-1:0] stage_flit;
  logic                 [sb_bridge_pkg::num_chan-1:0] pop;

  // first flit decode and register access filtering
  flit_classifier classifier_inst (
    .side_clk    (side_clk),
    .side_rst_b  (side_rst_b),
    .pc_put      (pc_put),
    .np_put      (np_put),
    .in_flit     (in_flit),
    .load        (load),
    .load_flit   (load_flit),
    .regacc_drop (regacc_drop)
  );

  // one holding stage per channel, indexed by chan_e
  for (genvar g = 0; g < sb_bridge_pkg::num_chan; g++) begin : gen_stage
    flit_stage stage_inst (
      .side_clk   (side_clk),
      .side_rst_b (side_rst_b),
      .load       (load[g]),
      .load_flit  (load_flit),
      .pop        (pop[g]),
      .valid      (valid[g]),
      .stage_flit (stage_flit[g])
    );
  end

  // drains both stages onto the single egress port
  egress_select selector_inst (
    .side_clk   (side_clk),
    .side_rst_b (side_rst_b),
    .valid      (valid),
    .stage_flit (stage_flit),
    .m_trdy     (m_trdy),
    .m_put      (m_put),
    .m_np       (m_np),
    .m_flit     (m_flit),
    .pop        (pop),
    .pc_free    (pc_free),
    .np_free    (np_free)
  );

endmodule

// File: src/sb_bridge_pkg.sv
// sideband bridge shared definitions

package sb_bridge_pkg;

  // ------------------------------------------------------------
  // message format
  // ------------------------------------------------------------

  // payload bits carried by every flit
  localparam int pld_w = 32;

  // the opcode sits in bits 23:16 of the first flit of a message
  localparam int opc_lsb = 16;
  localparam int opc_w = 8;

  // posted/completion and non-posted
  localparam int num_chan = 2;

  // one flit as it moves through the bridge
  typedef struct packed {
    logic             eom;
    logic [pld_w-1:0] payload;
  } flit_t;

  // channel number, also used to index the per channel stage arrays
  typedef enum logic [0:0] {
    chan_pc = 1'b0,
    chan_np = 1'b1
  } chan_e;

  // register access opcodes, all of them kept out of the forward path
  typedef enum logic [opc_w-1:0] {
    op_mrd   = 8'h00,
    op_mwr   = 8'h01,
    op_iord  = 8'h02,
    op_iowr  = 8'h03,
    op_cfgrd = 8'h04,
    op_cfgwr = 8'h05,
    op_crrd  = 8'h06,
    op_crwr  = 8'h07
  } opcode_e;

  // per channel message tracking in the classifier
  typedef enum logic [1:0] {
    st_first = 2'd0,
    st_fwd   = 2'd1,
    st_drop  = 2'd2
  } msg_state_e;

  // true for any of the eight register access opcodes
  function automatic logic is_regacc(input logic [opc_w-1:0] opc);
    case (opcode_e'(opc))
      op_mrd, op_mwr, op_iord, op_iowr,
      op_cfgrd, op_cfgwr, op_crrd, op_crwr: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage
